// File: Makefile
TOOL       ?= verilator
TOP        := bp_correlator_tb
RTL_TOP    := bp_correlator
FILELIST   := bp_correlator.f
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := === FAIL ===

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bp_correlator.f
+incdir+rtl
rtl/bp_pkg.sv
rtl/bp_cfg_if.sv
rtl/bp_regs.sv
rtl/bp_sampler.sv
rtl/bp_pair_corr.sv
rtl/bp_led_pwm.sv
rtl/bp_correlator.sv
dv/bp_correlator_assertions.sv
dv/bp_correlator_tb.sv

// File: dv/bp_correlator_assertions.sv
`timescale 1ns/1ns

module bp_correlator_assertions (
  input logic clk_48MHz,
  input logic rst,
  input logic i_enable,
  input logic i_sample_stb,
  input logic i_done0
);

  // Sampler strobe, observed where the correlator takes it in
  stb_only_enabled: assert property (
    @(posedge clk_48MHz) disable iff (rst) !i_enable |-> !i_sample_stb
  ) else $error("sample strobe seen while sampling is disabled");

  done_one_cycle: assert property (
    @(posedge clk_48MHz) disable iff (rst) i_done0 |=> !i_done0
  ) else $error("window done held longer than one cycle");

endmodule

bind bp_pair_corr bp_correlator_assertions u_assertions (
  .clk_48MHz    (clk_48MHz),
  .rst          (rst),
  .i_enable     (cfg.enable),
  .i_sample_stb (i_sample_stb),
  .i_done0      (o_result[0].done)
);

// File: dv/bp_correlator_tb.sv
`timescale 1ns/1ns
`include "bp_consts.svh"

module bp_correlator_tb
  import bp_pkg::*;
();

  logic                   clk_48MHz;
  logic                   rst;
  logic [`BP_N_PROBE-1:0] i_probe;
  logic                   i_wr;
  logic [`BP_ADDR_W-1:0]  i_addr;
  logic [`BP_DATA_W-1:0]  i_wdata;
  logic [`BP_DATA_W-1:0]  o_rdata;
  logic [`BP_N_PAIR-1:0]  o_led;
  int                     errors;
  int                     test_errors;
  int                     tests_run;
  int                     tests_failed;
  logic [31:0]            rng_state;

  bp_correlator u_bp_correlator (.*);

  initial begin
    clk_48MHz = 1'b0;
    forever #20 clk_48MHz = ~clk_48MHz;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
  endfunction

  task automatic reg_write(input logic [3:0] addr, input logic [15:0] data);
    @(posedge clk_48MHz);
    #2;
    i_wr    = 1'b1;
    i_addr  = addr;
    i_wdata = data;
    @(posedge clk_48MHz);
    #2;
    i_wr = 1'b0;
  endtask

  task automatic reg_read(input logic [3:0] addr, output logic [15:0] data);
    @(posedge clk_48MHz);
    #2;
    i_addr = addr;
    #10;
    data = o_rdata; // Read data is combinational on the address
  endtask

  task automatic check_reg(input logic [3:0] addr, input logic [15:0] exp, input string what);
    logic [15:0] got;
    reg_read(addr, got);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s read 0x%04h, expected 0x%04h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    errors += test_errors;
    if (test_errors != 0) tests_failed++;
    $display("test %-16s %s, %0d errors", name, (test_errors == 0) ? "ok" : "failed", test_errors);
    test_errors = 0;
  endtask

  task automatic count_led_high(output int h0, output int h1);
    h0 = 0;
    h1 = 0;
    repeat (256) begin
      @(posedge clk_48MHz);
      #12;
      if (o_led[0]) h0++;
      if (o_led[1]) h1++;
    end
  endtask

  task automatic wait_wincnt(input logic [15:0] target);
    logic [15:0] cnt;
    int          n;
    n = 0;
    reg_read(BP_WINCNT, cnt);
    while (cnt < target && n < 20000) begin
      reg_read(BP_WINCNT, cnt);
      n++;
    end
    if (cnt < target) begin
      $display("Timeout: window count stuck at %0d while waiting for %0d", cnt, target);
      $display("=== FAIL ===");
      $finish;
    end
  endtask

  // Pattern is held static, so every full window is all-agree or none-agree
  task automatic run_window(input logic [3:0] pattern, input logic [15:0] period,
                            input logic [15:0] win_exp);
    logic [15:0] start;
    @(posedge clk_48MHz);
    #2;
    i_probe = pattern;
    reg_write(BP_PERIOD, period);
    reg_write(BP_WINEXP, win_exp);
    reg_write(BP_CTRL, 16'd1);
    reg_read(BP_WINCNT, start);
    wait_wincnt(start + 16'd2); // Second window after clear is clean
  endtask

  task automatic check_metrics(input logic [3:0] pattern);
    check_reg(BP_METRIC0, (pattern[0] == pattern[1]) ? 16'hFFFF : 16'h0000, "METRIC0");
    check_reg(BP_METRIC1, (pattern[2] == pattern[3]) ? 16'hFFFF : 16'h0000, "METRIC1");
  endtask

  task automatic test_reset_values();
    int h0;
    int h1;
    check_reg(BP_CTRL, 16'd0, "CTRL");
    check_reg(BP_PERIOD, 16'd0, "PERIOD");
    check_reg(BP_WINEXP, 16'd4, "WINEXP");
    check_reg(BP_METRIC0, 16'd0, "METRIC0");
    check_reg(BP_METRIC1, 16'd0, "METRIC1");
    check_reg(BP_WINCNT, 16'd0, "WINCNT");
    count_led_high(h0, h1);
    if (h0 != 0 || h1 != 0) begin
      $display("[ERROR] %0t: LEDs high for %0d/%0d cycles after reset", $time, h0, h1);
      test_errors++;
    end
    finish_test("reset_values");
  endtask

  task automatic test_register_access();
    reg_write(BP_PERIOD, 16'h1234);
    check_reg(BP_PERIOD, 16'h1234, "PERIOD");
    reg_write(BP_WINEXP, 16'd0);
    check_reg(BP_WINEXP, 16'd1, "WINEXP low clamp");
    reg_write(BP_WINEXP, 16'd20);
    check_reg(BP_WINEXP, 16'd16, "WINEXP high clamp");
    reg_write(BP_METRIC0, 16'hA5A5); // Read-only
    reg_write(BP_METRIC1, 16'h5A5A);
    check_reg(BP_METRIC0, 16'h0000, "METRIC0 after write"); // No window has run yet
    check_reg(BP_METRIC1, 16'h0000, "METRIC1 after write");
    finish_test("register_access");
  endtask

  task automatic test_static_probes();
    run_window(4'b0100, 16'd1, 16'd3); // Pair 0 equal, pair 1 opposite
    check_metrics(4'b0100);
    finish_test("static_probes");
  endtask

  task automatic test_random_patterns();
    logic [31:0] r;
    logic [15:0] prev;
    logic [15:0] cnt;
    reg_read(BP_WINCNT, prev);
    repeat (6) begin
      rng_state = xorshift32(rng_state);
      r = rng_state;
      run_window(r[3:0], 16'(r[6:4]), 16'd1 + 16'(r[15:8] % 8'd6));
      check_metrics(r[3:0]);
      reg_read(BP_WINCNT, cnt);
      if (cnt <= prev) begin
        $display("[ERROR] %0t: WINCNT went from %0d to %0d", $time, prev, cnt);
        test_errors++;
      end
      prev = cnt;
    end
    finish_test("random_patterns");
  endtask

  task automatic test_disable();
    logic [15:0] c0;
    reg_write(BP_PERIOD, 16'd0); // Short windows right up to the stop
    reg_write(BP_WINEXP, 16'd1);
    reg_write(BP_CTRL, 16'd0);
    reg_read(BP_WINCNT, c0);
    repeat (500) @(posedge clk_48MHz);
    check_reg(BP_WINCNT, c0, "WINCNT while disabled");
    check_metrics(i_probe); // Last static pattern still decides both metrics
    finish_test("disable");
  endtask

  task automatic test_led_duty();
    int h0;
    int h1;
    run_window(4'b1000, 16'd0, 16'd2); // METRIC0 full, METRIC1 zero
    check_metrics(4'b1000);
    count_led_high(h0, h1);
    if (h0 != 255 || h1 != 0) begin
      $display("[ERROR] %0t: LED high counts %0d/%0d, expected 255/0", $time, h0, h1);
      test_errors++;
    end
    finish_test("led_duty");
  endtask

  initial begin
    rst          = 1'b1;
    i_probe      = '0;
    i_wr         = 1'b0;
    i_addr       = '0;
    i_wdata      = '0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    rng_state    = 32'haa46;
    repeat (8) @(posedge clk_48MHz);
    #2;
    rst = 1'b0;
    test_reset_values();
    test_register_access();
    test_static_probes();
    test_random_patterns();
    test_disable();
    test_led_duty();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: rtl/bp_cfg_if.sv
`timescale 1ns/1ns
`include "bp_consts.svh"

interface bp_cfg_if;

  logic                   enable;  // Sampling enable
  logic [`BP_PERIOD_W-1:0] period; // Strobe every period+1 cycles
  logic [`BP_EXP_W-1:0]    win_exp; // Window is 2^win_exp samples
  logic                   clear;   // One-cycle restart pulse

  modport cfg (
    output enable,
    output period,
    output win_exp,
    output clear
  );

  modport user (
    input enable,
    input period,
    input win_exp,
    input clear
  );

endinterface

// File: rtl/bp_consts.svh
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// Probe and pair geometry
`define BP_N_PROBE 4
`define BP_N_PAIR 2

// Field widths
`define BP_PERIOD_W 15
`define BP_EXP_W 5
`define BP_METRIC_W 16
`define BP_PWM_W 8

// Window exponent limits and reset value
`define BP_MIN_WIN_EXP 1
`define BP_MAX_WIN_EXP 16
`define BP_WINEXP_RST 4

// Register bus
`define BP_ADDR_W 4
`define BP_DATA_W 16

`endif

// File: rtl/bp_correlator.sv
`timescale 1ns/1ns
`include "bp_consts.svh"

module bp_correlator
  import bp_pkg::*;
(
  input  logic                   clk_48MHz,
  input  logic                   rst,
  input  logic [`BP_N_PROBE-1:0] i_probe,
  input  logic                   i_wr,
  input  logic [`BP_ADDR_W-1:0]  i_addr,
  input  logic [`BP_DATA_W-1:0]  i_wdata,
  output logic [`BP_DATA_W-1:0]  o_rdata,
  output logic [`BP_N_PAIR-1:0]  o_led
);

  bp_cfg_if cfg ();

  logic                    sample_stb;
  logic [`BP_N_PROBE-1:0]  probe_s;
  bp_result_t              result [`BP_N_PAIR];
  logic [`BP_METRIC_W-1:0] metric [`BP_N_PAIR];

  for (genvar p = 0; p < `BP_N_PAIR; p++) begin : g_metric
    assign metric[p] = result[p].metric;
  end

  bp_regs u_regs (
    .clk_48MHz (clk_48MHz),
    .rst       (rst),
    .i_wr      (i_wr),
    .i_addr    (i_addr),
    .i_wdata   (i_wdata),
    .o_rdata   (o_rdata),
    .i_result  (result),
    .cfg       (cfg.cfg)
  );

  bp_sampler u_sampler (
    .clk_48MHz    (clk_48MHz),
    .rst          (rst),
    .i_probe      (i_probe),
    .cfg          (cfg.user),
    .o_sample_stb (sample_stb),
    .o_probe_s    (probe_s)
  );

  bp_pair_corr u_pair_corr (
    .clk_48MHz    (clk_48MHz),
    .rst          (rst),
    .cfg          (cfg.user),
    .i_sample_stb (sample_stb),
    .i_probe_s    (probe_s),
    .o_result     (result)
  );

  bp_led_pwm u_led_pwm (
    .clk_48MHz (clk_48MHz),
    .rst       (rst),
    .i_metric  (metric),
    .o_led     (o_led)
  );

endmodule

// File: rtl/bp_led_pwm.sv
`timescale 1ns/1ns
`include "bp_consts.svh"

module bp_led_pwm (
  input  logic                    clk_48MHz,
  input  logic                    rst,
  input  logic [`BP_METRIC_W-1:0] i_metric [`BP_N_PAIR],
  output logic [`BP_N_PAIR-1:0]   o_led
);

  logic [`BP_PWM_W-1:0] pwm_cnt;

  // Free-running, shared by all LEDs
  always_ff @(posedge clk_48MHz) begin
    if (rst)
      pwm_cnt <= '0;
    else
      pwm_cnt <= pwm_cnt + 1'b1;
  end

  always_ff @(posedge clk_48MHz) begin
    if (rst) begin
      o_led <= '0;
    end else begin
      for (int p = 0; p < `BP_N_PAIR; p++)
        o_led[p] <= pwm_cnt < i_metric[p][`BP_METRIC_W-1 -: `BP_PWM_W]; // Top bits set duty
    end
  end

endmodule

// File: rtl/bp_pair_corr.sv
`timescale 1ns/1ns
`include "bp_consts.svh"

module bp_pair_corr
  import bp_pkg::*;
(
  input  logic                   clk_48MHz,
  input  logic                   rst,
  bp_cfg_if.user                 cfg,
  input  logic                   i_sample_stb,
  input  logic [`BP_N_PROBE-1:0] i_probe_s,
  output bp_result_t             o_result [`BP_N_PAIR]
);

  logic [`BP_MAX_WIN_EXP-1:0] smp_cnt;
  logic [`BP_MAX_WIN_EXP:0]   win_last;
  logic                       win_end;
  logic [`BP_EXP_W-1:0]       shift;
  logic                       done_q;

  assign win_last = ((`BP_MAX_WIN_EXP+1)'(1) << cfg.win_exp) - 1'b1;
  assign win_end  = ({1'b0, smp_cnt} >= win_last); // Also catches a shrunk window
  assign shift    = `BP_EXP_W'(`BP_MAX_WIN_EXP) - cfg.win_exp;

  // Sample counter shared by all pairs
  always_ff @(posedge clk_48MHz) begin
    if (rst || cfg.clear) begin
      smp_cnt <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= i_sample_stb && win_end;
      if (i_sample_stb)
        smp_cnt <= win_end ? '0 : smp_cnt + 1'b1;
    end
  end

  for (genvar p = 0; p < `BP_N_PAIR; p++) begin : g_pair
    logic                           agree;
    logic [`BP_MAX_WIN_EXP:0]       agree_cnt;
    logic [`BP_MAX_WIN_EXP:0]       agree_nxt;
    logic [2*`BP_MAX_WIN_EXP-1:0]   scaled;
    logic [`BP_METRIC_W-1:0]        metric_q;

    assign agree     = i_probe_s[2*p] ~^ i_probe_s[2*p+1];
    assign agree_nxt = agree_cnt + agree;
    assign scaled    = (2*`BP_MAX_WIN_EXP)'(agree_nxt) << shift; // Normalise to 2^16

    always_ff @(posedge clk_48MHz) begin
      if (rst) begin
        agree_cnt <= '0;
        metric_q  <= '0;
      end else if (cfg.clear) begin
        agree_cnt <= '0; // Metric keeps last window
      end else if (i_sample_stb) begin
        if (win_end) begin
          agree_cnt <= '0;
          if ((scaled >> `BP_METRIC_W) != '0)
            metric_q <= '1; // Saturate full agreement
          else
            metric_q <= scaled[`BP_METRIC_W-1:0];
        end else begin
          agree_cnt <= agree_nxt;
        end
      end
    end

    assign o_result[p].metric = metric_q;
    assign o_result[p].done   = done_q; // Pairs finish together
  end

endmodule

// File: rtl/bp_pkg.sv
`include "bp_consts.svh"

package bp_pkg;

  // Register map, CTRL bit 0 is the enable
  typedef enum logic [`BP_ADDR_W-1:0] {
    BP_CTRL    = 4'd0,
    BP_PERIOD  = 4'd1,
    BP_WINEXP  = 4'd2,
    BP_METRIC0 = 4'd4,
    BP_METRIC1 = 4'd5,
    BP_WINCNT  = 4'd6
  } bp_reg_e;

  // Result of one probe pair at the end of a window
  typedef struct packed {
    logic [`BP_METRIC_W-1:0] metric; // Scaled agreement count
    logic                    done;   // One-cycle end-of-window strobe
  } bp_result_t;

endpackage

// File: rtl/bp_regs.sv
`timescale 1ns/1ns
`include "bp_consts.svh"

module bp_regs
  import bp_pkg::*;
(
  input  logic                  clk_48MHz,
  input  logic                  rst,
  input  logic                  i_wr,
  input  logic [`BP_ADDR_W-1:0] i_addr,
  input  logic [`BP_DATA_W-1:0] i_wdata,
  output logic [`BP_DATA_W-1:0] o_rdata,
  input  bp_result_t            i_result [`BP_N_PAIR],
  bp_cfg_if.cfg                 cfg
);

  logic                     ctrl_en;
  logic [`BP_PERIOD_W-1:0]  period_q;
  logic [`BP_EXP_W-1:0]     win_exp_q;
  logic                     clear_q;
  logic [`BP_METRIC_W-1:0]  metric_q [`BP_N_PAIR];
  logic [`BP_DATA_W-1:0]    wincnt_q;
  logic [`BP_N_PAIR-1:0]    done_v;

  always_ff @(posedge clk_48MHz) begin
    if (rst) begin
      ctrl_en   <= 1'b0;
      period_q  <= '0;
      win_exp_q <= `BP_EXP_W'(`BP_WINEXP_RST);
      clear_q   <= 1'b0;
    end else begin
      clear_q <= i_wr && (i_addr == BP_CTRL); // Restart on any CTRL write
      if (i_wr) begin
        case (i_addr)
          BP_CTRL:   ctrl_en  <= i_wdata[0];
          BP_PERIOD: period_q <= i_wdata[`BP_PERIOD_W-1:0];
          BP_WINEXP: begin
            if (i_wdata < `BP_DATA_W'(`BP_MIN_WIN_EXP))
              win_exp_q <= `BP_EXP_W'(`BP_MIN_WIN_EXP);
            else if (i_wdata > `BP_DATA_W'(`BP_MAX_WIN_EXP))
              win_exp_q <= `BP_EXP_W'(`BP_MAX_WIN_EXP);
            else
              win_exp_q <= i_wdata[`BP_EXP_W-1:0];
          end
          default: ; // Read-only or unmapped
        endcase
      end
    end
  end

  always_comb begin
    for (int p = 0; p < `BP_N_PAIR; p++)
      done_v[p] = i_result[p].done;
  end

  // Results captured at window end
  always_ff @(posedge clk_48MHz) begin
    if (rst) begin
      for (int p = 0; p < `BP_N_PAIR; p++)
        metric_q[p] <= '0;
      wincnt_q <= '0;
    end else begin
      for (int p = 0; p < `BP_N_PAIR; p++)
        if (done_v[p]) metric_q[p] <= i_result[p].metric;
      if (|done_v) wincnt_q <= wincnt_q + 1'b1; // Wraps
    end
  end

  always_comb begin
    o_rdata = '0;
    case (i_addr)
      BP_CTRL:    o_rdata[0] = ctrl_en;
      BP_PERIOD:  o_rdata[`BP_PERIOD_W-1:0] = period_q;
      BP_WINEXP:  o_rdata[`BP_EXP_W-1:0] = win_exp_q;
      BP_METRIC0: o_rdata = metric_q[0];
      BP_METRIC1: o_rdata = metric_q[1];
      BP_WINCNT:  o_rdata = wincnt_q;
      default:    o_rdata = '0;
    endcase
  end

  assign cfg.enable  = ctrl_en;
  assign cfg.period  = period_q;
  assign cfg.win_exp = win_exp_q;
  assign cfg.clear   = clear_q;

endmodule

// File: rtl/bp_sampler.sv
`timescale 1ns/1ns
`include "bp_consts.svh"

module bp_sampler (
  input  logic                   clk_48MHz,
  input  logic                   rst,
  input  logic [`BP_N_PROBE-1:0] i_probe,
  bp_cfg_if.user                 cfg,
  output logic                   o_sample_stb,
  output logic [`BP_N_PROBE-1:0] o_probe_s
);

  logic [`BP_N_PROBE-1:0]  sync_q;
  logic [`BP_PERIOD_W-1:0] cnt_q;

  // Two-flop synchroniser per probe
  always_ff @(posedge clk_48MHz) begin
    sync_q    <= i_probe;
    o_probe_s <= sync_q;
  end

  // Period down-counter
  always_ff @(posedge clk_48MHz) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (cfg.clear) begin
      cnt_q <= cfg.period; // Restart the period
    end else if (cfg.enable) begin
      if (cnt_q == '0)
        cnt_q <= cfg.period; // Reload on expiry
      else
        cnt_q <= cnt_q - 1'b1;
    end
  end

  // First strobe lands period+1 cycles after clear
  assign o_sample_stb = cfg.enable && !cfg.clear && (cnt_q == '0);

endmodule
